// File: game_pkg.sv
// ==========================================================================
// Shared definitions for the ROM subsystem of the arcade board:
// SDRAM geometry, ROM region offsets, download map for the PROMs,
// core reset hold time, arbiter client and state enums
// ==========================================================================

package game_pkg;

    // SDRAM geometry, word addressed, 32-bit reads
    localparam int SDRAM_AW = 22;
    localparam int SDRAM_DW = 32;

    // Client address widths (main and sound in bytes, char in halfwords)
    localparam int MAIN_AW = 16;
    localparam int SND_AW  = 15;
    localparam int CHAR_AW = 14;

    // ROM regions sit back to back, offsets in 32-bit words
    localparam logic [SDRAM_AW-1:0] MAIN_OFFSET = '0;
    localparam logic [SDRAM_AW-1:0] SND_OFFSET  = MAIN_OFFSET + (1 << (MAIN_AW - 2));
    localparam logic [SDRAM_AW-1:0] CHAR_OFFSET = SND_OFFSET + (1 << (SND_AW - 2));

    // Download bytes from here on go to the PROMs, 256 bytes each
    localparam logic [21:0] PROM_START = 22'h02_0000;
    localparam int          PROM_COUNT = 6;

    // Core reset is held this many cycles after the download ends
    localparam int RST_HOLD = 2;
    localparam int RST_CW   = $clog2(RST_HOLD + 1);

    typedef enum logic [1:0] {
        CLI_MAIN,
        CLI_SND,
        CLI_CHAR
    } client_e;

    // One arbiter input per client
    localparam int NUM_CLI = int'(CLI_CHAR) + 1;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_DATA
    } arb_state_e;

endpackage

// File: clk_en_gen.sv
// ==========================================================================
// Clock enable generator: one-cycle strobes at 1/2, 1/4 and 1/8 of clk,
// all aligned on counter value zero
// ==========================================================================

module clk_en_gen (
    input  logic clk,
    input  logic arst_n,
    output logic cen12,
    output logic cen6,
    output logic cen3
);

    logic [2:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt   <= 3'd0;
            cen12 <= 1'b0;
            cen6  <= 1'b0;
            cen3  <= 1'b0;
        end else begin
            cnt   <= cnt + 3'd1;
            // Strobes registered from the count, so they line up
            cen12 <= (cnt[0]   == 1'b0);
            cen6  <= (cnt[1:0] == 2'd0);
            cen3  <= (cnt      == 3'd0);
        end
    end

endmodule

// File: rom_reader.sv
// ==========================================================================
// ROM client with a single 32-bit word cache
// Hits answer combinationally, misses request a refill through the
// arbiter using valid/ready and wait for the one-cycle response
// ==========================================================================

module rom_reader import game_pkg::*; #(
    parameter  int AW  = 16,
    parameter  int DW  = 8,
    localparam int LW  = (DW == 8) ? 2 : 1,
    localparam int WAW = AW - LW
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                cs,
    input  logic [AW-1:0]       addr,
    output logic [DW-1:0]       data,
    output logic                ok,
    output logic                rd_valid,
    output logic [WAW-1:0]      rd_word,
    input  logic                rd_ready,
    input  logic                rsp_valid,
    input  logic [SDRAM_DW-1:0] rsp_data
);

    logic [SDRAM_DW-1:0] cache_word;
    logic [WAW-1:0]      cache_tag;
    logic                cache_vld;
    logic                wait_rsp;
    logic                stale;
    logic [WAW-1:0]      addr_word;
    logic [LW-1:0]       lane;
    logic                hit;
    logic                busy;
    logic                start_miss;

    assign addr_word  = addr[AW-1:LW];
    assign lane       = addr[LW-1:0];
    assign hit        = cache_vld && (cache_tag == addr_word);
    assign busy       = rd_valid || wait_rsp;
    assign start_miss = cs && !hit && !busy;

    // Little-endian lane select
    assign data = cache_word[lane*DW +: DW];
    assign ok   = cs && hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cache_vld <= 1'b0;
            rd_valid  <= 1'b0;
            wait_rsp  <= 1'b0;
            stale     <= 1'b0;
        end else begin
            if (flush) begin
                cache_vld <= 1'b0;
            end
            // A refill already granted before the flush brings old data
            if (flush && wait_rsp) begin
                stale <= 1'b1;
            end
            if (rd_valid && rd_ready) begin
                rd_valid <= 1'b0;
                wait_rsp <= 1'b1;
            end else if (start_miss) begin
                rd_valid <= 1'b1;
            end
            if (rsp_valid) begin
                wait_rsp  <= 1'b0;
                stale     <= 1'b0;
                cache_vld <= !flush && !stale;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_miss) begin
            rd_word <= addr_word;
        end
        if (rsp_valid) begin
            cache_word <= rsp_data;
            cache_tag  <= rd_word;
        end
    end

endmodule

// File: sdram_arbiter.sv
// ==========================================================================
// Round-robin arbiter of the ROM readers onto the single SDRAM port
// Adds the region offset of the granted client and routes the returned
// word back to it as a one-cycle response
// ==========================================================================

module sdram_arbiter import game_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                downloading,
    input  logic [NUM_CLI-1:0]  rd_valid,
    input  logic [MAIN_AW-3:0]  rd_word_main,
    input  logic [SND_AW-3:0]   rd_word_snd,
    input  logic [CHAR_AW-2:0]  rd_word_char,
    output logic [NUM_CLI-1:0]  rd_ready,
    output logic [NUM_CLI-1:0]  rsp_valid,
    output logic [SDRAM_DW-1:0] rsp_data,
    output logic                sdram_req,
    output logic [SDRAM_AW-1:0] sdram_addr,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  logic [SDRAM_DW-1:0] data_read
);

    arb_state_e          state;
    client_e             cur_cli;
    client_e             last_cli;
    client_e             pick;
    logic                pick_vld;
    logic                grant;
    logic [SDRAM_AW-1:0] next_addr;

    // Search starts just after the client served last
    always_comb begin
        int idx;
        pick_vld = 1'b0;
        pick     = last_cli;
        for (int i = 1; i <= NUM_CLI; i++) begin
            idx = (int'(last_cli) + i) % NUM_CLI;
            if (!pick_vld && rd_valid[idx]) begin
                pick_vld = 1'b1;
                pick     = client_e'(idx);
            end
        end
    end

    assign grant    = (state == ARB_IDLE) && !downloading && pick_vld;
    assign rd_ready = grant ? (NUM_CLI'(1) << pick) : '0;

    always_comb begin
        case (pick)
            CLI_SND:  next_addr = SND_OFFSET + SDRAM_AW'(rd_word_snd);
            CLI_CHAR: next_addr = CHAR_OFFSET + SDRAM_AW'(rd_word_char);
            default:  next_addr = MAIN_OFFSET + SDRAM_AW'(rd_word_main);
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ARB_IDLE;
            sdram_req <= 1'b0;
            rsp_valid <= '0;
            cur_cli   <= CLI_MAIN;
            last_cli  <= CLI_CHAR;
        end else begin
            rsp_valid <= '0;
            case (state)
                ARB_IDLE: begin
                    if (grant) begin
                        sdram_req <= 1'b1;
                        cur_cli   <= pick;
                        last_cli  <= pick;
                        state     <= ARB_WAIT_ACK;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ARB_WAIT_DATA;
                    end
                end
                ARB_WAIT_DATA: begin
                    if (data_rdy) begin
                        rsp_valid <= NUM_CLI'(1) << cur_cli;
                        state     <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            sdram_addr <= next_addr;
        end
        if (state == ARB_WAIT_DATA && data_rdy) begin
            rsp_data <= data_read;
        end
    end

endmodule

// File: rom_loader.sv
// ==========================================================================
// ROM download loader
// Byte stream to SDRAM halfword programming writes or PROM strobes,
// plus the game core reset held across the download
// ==========================================================================

module rom_loader import game_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  downloading,
    input  logic [21:0]           ioctl_addr,
    input  logic [7:0]            ioctl_data,
    input  logic                  ioctl_wr,
    output logic [21:0]           prog_addr,
    output logic [7:0]            prog_data,
    output logic [1:0]            prog_mask,
    output logic                  prog_we,
    output logic [PROM_COUNT-1:0] prom_we,
    output logic                  core_rst
);

    logic              wr_en;
    logic              is_prom;
    logic [21:0]       prom_off;
    logic [13:0]       prom_idx;
    logic [RST_CW-1:0] rst_cnt;

    assign wr_en    = downloading && ioctl_wr;
    assign is_prom  = ioctl_addr >= PROM_START;
    assign prom_off = ioctl_addr - PROM_START;
    assign prom_idx = prom_off[21:8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
            prom_we <= '0;
        end else begin
            prog_we <= wr_en && !is_prom;
            // Addresses past the last PROM are dropped
            if (wr_en && is_prom && prom_idx < 14'(PROM_COUNT)) begin
                prom_we <= PROM_COUNT'(1) << prom_idx;
            end else begin
                prom_we <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            prog_data <= ioctl_data;
            if (is_prom) begin
                prog_addr <= {14'd0, ioctl_addr[7:0]};
                prog_mask <= 2'b11;
            end else begin
                prog_addr <= {1'b0, ioctl_addr[21:1]};
                // Active low byte enables, even byte is the low half
                prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            core_rst <= 1'b1;
            rst_cnt  <= '0;
        end else if (downloading) begin
            core_rst <= 1'b1;
            rst_cnt  <= '0;
        end else if (core_rst) begin
            if (rst_cnt == RST_CW'(RST_HOLD - 1)) begin
                core_rst <= 1'b0;
            end else begin
                rst_cnt <= rst_cnt + 1'b1;
            end
        end
    end

endmodule

// File: game_rom_sys.sv
// ==========================================================================
// ROM subsystem top: clock enables, main/sound/char ROM readers,
// SDRAM arbiter and download loader
// ==========================================================================

module game_rom_sys import game_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic                  cen12,
    output logic                  cen6,
    output logic                  cen3,
    output logic                  core_rst,
    // SDRAM port
    output logic                  sdram_req,
    output logic [SDRAM_AW-1:0]   sdram_addr,
    input  logic                  sdram_ack,
    input  logic                  data_rdy,
    input  logic [SDRAM_DW-1:0]   data_read,
    // Download
    input  logic                  downloading,
    input  logic [21:0]           ioctl_addr,
    input  logic [7:0]            ioctl_data,
    input  logic                  ioctl_wr,
    output logic [21:0]           prog_addr,
    output logic [7:0]            prog_data,
    output logic [1:0]            prog_mask,
    output logic                  prog_we,
    output logic [PROM_COUNT-1:0] prom_we,
    // ROM readers
    input  logic                  main_cs,
    input  logic [MAIN_AW-1:0]    main_addr,
    output logic [7:0]            main_data,
    output logic                  main_ok,
    input  logic                  snd_cs,
    input  logic [SND_AW-1:0]     snd_addr,
    output logic [7:0]            snd_data,
    output logic                  snd_ok,
    input  logic                  char_cs,
    input  logic [CHAR_AW-1:0]    char_addr,
    output logic [15:0]           char_data,
    output logic                  char_ok
);

    logic [NUM_CLI-1:0]  rd_valid;
    logic [NUM_CLI-1:0]  rd_ready;
    logic [NUM_CLI-1:0]  rsp_valid;
    logic [SDRAM_DW-1:0] rsp_data;
    logic [MAIN_AW-3:0]  rd_word_main;
    logic [SND_AW-3:0]   rd_word_snd;
    logic [CHAR_AW-2:0]  rd_word_char;

    clk_en_gen u_cen (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cen12  ( cen12  ),
        .cen6   ( cen6   ),
        .cen3   ( cen3   )
    );

    rom_reader #(.AW(MAIN_AW), .DW(8)) u_main (
        .clk       ( clk                 ),
        .arst_n    ( arst_n              ),
        .flush     ( downloading         ),
        .cs        ( main_cs             ),
        .addr      ( main_addr           ),
        .data      ( main_data           ),
        .ok        ( main_ok             ),
        .rd_valid  ( rd_valid[CLI_MAIN]  ),
        .rd_word   ( rd_word_main        ),
        .rd_ready  ( rd_ready[CLI_MAIN]  ),
        .rsp_valid ( rsp_valid[CLI_MAIN] ),
        .rsp_data  ( rsp_data            )
    );

    rom_reader #(.AW(SND_AW), .DW(8)) u_snd (
        .clk       ( clk                ),
        .arst_n    ( arst_n             ),
        .flush     ( downloading        ),
        .cs        ( snd_cs             ),
        .addr      ( snd_addr           ),
        .data      ( snd_data           ),
        .ok        ( snd_ok             ),
        .rd_valid  ( rd_valid[CLI_SND]  ),
        .rd_word   ( rd_word_snd        ),
        .rd_ready  ( rd_ready[CLI_SND]  ),
        .rsp_valid ( rsp_valid[CLI_SND] ),
        .rsp_data  ( rsp_data           )
    );

    rom_reader #(.AW(CHAR_AW), .DW(16)) u_char (
        .clk       ( clk                 ),
        .arst_n    ( arst_n              ),
        .flush     ( downloading         ),
        .cs        ( char_cs             ),
        .addr      ( char_addr           ),
        .data      ( char_data           ),
        .ok        ( char_ok             ),
        .rd_valid  ( rd_valid[CLI_CHAR]  ),
        .rd_word   ( rd_word_char        ),
        .rd_ready  ( rd_ready[CLI_CHAR]  ),
        .rsp_valid ( rsp_valid[CLI_CHAR] ),
        .rsp_data  ( rsp_data            )
    );

    sdram_arbiter u_arb (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .downloading  ( downloading  ),
        .rd_valid     ( rd_valid     ),
        .rd_word_main ( rd_word_main ),
        .rd_word_snd  ( rd_word_snd  ),
        .rd_word_char ( rd_word_char ),
        .rd_ready     ( rd_ready     ),
        .rsp_valid    ( rsp_valid    ),
        .rsp_data     ( rsp_data     ),
        .sdram_req    ( sdram_req    ),
        .sdram_addr   ( sdram_addr   ),
        .sdram_ack    ( sdram_ack    ),
        .data_rdy     ( data_rdy     ),
        .data_read    ( data_read    )
    );

    rom_loader u_loader (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     ),
        .core_rst    ( core_rst    )
    );

endmodule

// File: sdram_model.sv
// ==========================================================================
// Behavioural SDRAM for the testbench: one access at a time, random
// acknowledge delay of 1 to 4 cycles and data delay of 2 to 6 cycles
// ==========================================================================

module sdram_model import game_pkg::*; (
    input  logic                clk,
    input  logic [SDRAM_DW-1:0] content,
    input  logic                sdram_req,
    output logic                sdram_ack,
    output logic                data_rdy,
    output logic [SDRAM_DW-1:0] data_read
);

    initial begin : serve
        int                  ack_dly;
        int                  dat_dly;
        logic [SDRAM_DW-1:0] word;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            #2;
            if (sdram_req) begin
                // Address is stable from the request, so take the word now
                word    = content;
                ack_dly = 1 + int'($urandom % 4);
                dat_dly = 2 + int'($urandom % 5);
                repeat (ack_dly - 1) begin
                    @(posedge clk);
                    #2;
                end
                sdram_ack = 1'b1;
                @(posedge clk);
                #2;
                sdram_ack = 1'b0;
                repeat (dat_dly - 1) begin
                    @(posedge clk);
                    #2;
                end
                data_rdy  = 1'b1;
                data_read = word;
                @(posedge clk);
                #2;
                data_rdy  = 1'b0;
            end
        end
    end

endmodule

// File: game_rom_sys_chk.sv
// ==========================================================================
// Handshake assertions for the ROM subsystem, bound into the top level:
// SDRAM request hold, reader request hold, one response per data return
// ==========================================================================

module game_rom_sys_chk import game_pkg::*; (
    input logic                clk,
    input logic                arst_n,
    input logic                sdram_req,
    input logic [SDRAM_AW-1:0] sdram_addr,
    input logic                sdram_ack,
    input logic                data_rdy,
    input logic [NUM_CLI-1:0]  rd_valid,
    input logic [NUM_CLI-1:0]  rd_ready,
    input logic [NUM_CLI-1:0]  rsp_valid,
    input logic [MAIN_AW-3:0]  rd_word_main,
    input logic [SND_AW-3:0]   rd_word_snd,
    input logic [CHAR_AW-2:0]  rd_word_char
);

    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else $error("sdram_req dropped or sdram_addr moved before sdram_ack");

    a_main_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid[CLI_MAIN] && !rd_ready[CLI_MAIN] |=>
        rd_valid[CLI_MAIN] && $stable(rd_word_main))
        else $error("main reader request not held until ready");

    a_snd_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid[CLI_SND] && !rd_ready[CLI_SND] |=>
        rd_valid[CLI_SND] && $stable(rd_word_snd))
        else $error("sound reader request not held until ready");

    a_char_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid[CLI_CHAR] && !rd_ready[CLI_CHAR] |=>
        rd_valid[CLI_CHAR] && $stable(rd_word_char))
        else $error("char reader request not held until ready");

    // Exactly one response for each data return, none otherwise
    a_one_rsp: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(rsp_valid) && ((rsp_valid != '0) == $past(data_rdy)))
        else $error("rsp_valid is not a single pulse one cycle after data_rdy");

endmodule

bind game_rom_sys game_rom_sys_chk u_chk (.*);

// File: tb_game_rom_sys.sv
// ==========================================================================
// Testbench for the ROM subsystem: clock and reset, SDRAM model hookup,
// reference ROM model, reader and download stimulus, data compare,
// grant fairness monitor and run timeout
// ==========================================================================

module tb_game_rom_sys import game_pkg::*; ();

    localparam int RAND_READS = 24;
    localparam int N_READS    = 3 * 2 + 3 * RAND_READS + 3;
    // Ack 4 plus data 6 plus arbiter and reader overhead
    localparam int WORST_LAT  = 14;
    localparam int MAX_CYCLES = 8 * N_READS * WORST_LAT;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  cen12, cen6, cen3, core_rst;
    logic                  sdram_req, sdram_ack, data_rdy;
    logic [SDRAM_AW-1:0]   sdram_addr;
    logic [SDRAM_DW-1:0]   data_read, sdram_content;
    logic                  downloading, ioctl_wr;
    logic [21:0]           ioctl_addr, prog_addr;
    logic [7:0]            ioctl_data, prog_data;
    logic [1:0]            prog_mask;
    logic                  prog_we;
    logic [PROM_COUNT-1:0] prom_we;
    logic                  main_cs, snd_cs, char_cs;
    logic [MAIN_AW-1:0]    main_addr;
    logic [SND_AW-1:0]     snd_addr;
    logic [CHAR_AW-1:0]    char_addr;
    logic [7:0]            main_data, snd_data;
    logic [15:0]           char_data;
    logic                  main_ok, snd_ok, char_ok;

    int err_val    = 0;
    int err_other  = 0;
    int n_checks   = 0;
    int req_starts = 0;
    int cycles     = 0;
    int grant_waits [NUM_CLI];
    logic req_prev = 1'b0;
    logic dl_prev  = 1'b0;

    always #10 clk = ~clk;

    game_rom_sys u_dut (.*);

    sdram_model u_sdram (
        .clk       ( clk           ),
        .content   ( sdram_content ),
        .sdram_req ( sdram_req     ),
        .sdram_ack ( sdram_ack     ),
        .data_rdy  ( data_rdy      ),
        .data_read ( data_read     )
    );

    // SDRAM content pattern, every address bit shows in the word
    function automatic logic [SDRAM_DW-1:0] sdram_word(input logic [SDRAM_AW-1:0] w);
        return {w, w[9:0] ^ 10'h2b5};
    endfunction

    assign sdram_content = sdram_word(sdram_addr);

    function automatic logic [15:0] expected_rom(input client_e cli, input int unsigned a);
        logic [SDRAM_AW-1:0] w;
        logic [SDRAM_DW-1:0] d;
        case (cli)
            CLI_MAIN: w = MAIN_OFFSET + SDRAM_AW'(a >> 2);
            CLI_SND:  w = SND_OFFSET + SDRAM_AW'(a >> 2);
            default:  w = CHAR_OFFSET + SDRAM_AW'(a >> 1);
        endcase
        d = sdram_word(w);
        if (cli == CLI_CHAR) begin
            return (a & 1) != 0 ? d[31:16] : d[15:0];
        end
        return {8'h00, d[8*(a & 3) +: 8]};
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        n_checks++;
        if (got !== exp) begin
            err_val++;
            $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_half(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        n_checks++;
        if (got !== exp) begin
            err_val++;
            $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            err_val++;
            $display("error t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Mask only matters for SDRAM writes
    task automatic check_prog(input logic we, input logic [21:0] addr,
                              input logic [7:0] data, input logic [1:0] mask);
        check_flag("prog_we", prog_we, we);
        n_checks++;
        if (prog_addr !== addr) begin
            err_val++;
            $display("error t=%0t prog_addr got %h expected %h", $time, prog_addr, addr);
        end
        check_byte("prog_data", prog_data, data);
        if (we && prog_mask !== mask) begin
            err_val++;
            $display("error t=%0t prog_mask got %b expected %b", $time, prog_mask, mask);
        end
    endtask

    task automatic check_prom(input logic [PROM_COUNT-1:0] exp);
        n_checks++;
        if (prom_we !== exp) begin
            err_val++;
            $display("error t=%0t prom_we got %b expected %b", $time, prom_we, exp);
        end
    endtask

    // Data compare on every cycle a reader claims valid data
    always @(negedge clk) begin
        if (arst_n) begin
            if (main_cs && main_ok) begin
                check_byte("main_data", main_data, 8'(expected_rom(CLI_MAIN, main_addr)));
            end
            if (snd_cs && snd_ok) begin
                check_byte("snd_data", snd_data, 8'(expected_rom(CLI_SND, snd_addr)));
            end
            if (char_cs && char_ok) begin
                check_half("char_data", char_data, expected_rom(CLI_CHAR, char_addr));
            end
        end
    end

    // SDRAM request starts, download blocking and grant fairness
    always @(negedge clk) begin
        if (sdram_req && !req_prev) begin
            req_starts++;
            if (dl_prev) begin
                err_other++;
                $display("%0t: SDRAM request started during the download", $time);
            end
        end
        req_prev = sdram_req;
        dl_prev  = downloading;
        for (int c = 0; c < NUM_CLI; c++) begin
            if (u_dut.rd_valid[c] && !u_dut.rd_ready[c]) begin
                if (|u_dut.rd_ready) begin
                    grant_waits[c]++;
                end
                if (grant_waits[c] > 3) begin
                    err_other++;
                    grant_waits[c] = 0;
                    $display("%0t: client %0d waited through more than three grants",
                             $time, c);
                end
            end else begin
                grant_waits[c] = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a reader or the download never finished",
                     cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic ok_of(input client_e cli);
        case (cli)
            CLI_MAIN: return main_ok;
            CLI_SND:  return snd_ok;
            default:  return char_ok;
        endcase
    endfunction

    // One read, returns the number of cycles spent waiting for ok
    task automatic do_read(input client_e cli, input int unsigned a, output int waited);
        @(posedge clk);
        #2;
        case (cli)
            CLI_MAIN: begin
                main_cs   = 1'b1;
                main_addr = MAIN_AW'(a);
            end
            CLI_SND: begin
                snd_cs   = 1'b1;
                snd_addr = SND_AW'(a);
            end
            default: begin
                char_cs   = 1'b1;
                char_addr = CHAR_AW'(a);
            end
        endcase
        waited = 0;
        @(negedge clk);
        while (!ok_of(cli)) begin
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic random_reads(input client_e cli, input int aw);
        int w;
        for (int i = 0; i < RAND_READS; i++) begin
            do_read(cli, $urandom & ((1 << aw) - 1), w);
        end
    endtask

    task automatic send_byte(input logic [21:0] a, input logic [7:0] d);
        int idx;
        @(posedge clk);
        #2;
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #2;
        ioctl_wr = 1'b0;
        @(negedge clk);
        check_flag("core_rst", core_rst, 1'b1);
        if (a < PROM_START) begin
            check_prog(1'b1, a >> 1, d, a[0] ? 2'b01 : 2'b10);
            check_prom('0);
        end else begin
            idx = int'((a - PROM_START) >> 8);
            check_prog(1'b0, {14'd0, a[7:0]}, d, 2'b11);
            check_prom(PROM_COUNT'(1) << idx);
        end
    endtask

    initial begin : stimulus
        int          w;
        int          starts;
        int unsigned a;
        int unsigned keep_addr;
        void'($urandom(32'hbdf));
        arst_n      = 1'b0;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        main_cs     = 1'b0;
        snd_cs      = 1'b0;
        char_cs     = 1'b0;
        main_addr   = '0;
        snd_addr    = '0;
        char_addr   = '0;
        grant_waits = '{default: 0};

        // Reset values
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_flag("sdram_req", sdram_req, 1'b0);
        check_flag("main_ok", main_ok, 1'b0);
        check_flag("snd_ok", snd_ok, 1'b0);
        check_flag("char_ok", char_ok, 1'b0);
        check_flag("prog_we", prog_we, 1'b0);
        check_prom('0);
        check_flag("core_rst", core_rst, 1'b1);
        check_flag("cen12", cen12, 1'b0);
        check_flag("cen6", cen6, 1'b0);
        check_flag("cen3", cen3, 1'b0);
        @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Enable strobes, aligned on the first cen3
        w = 0;
        @(negedge clk);
        while (!cen3 && w < 8) begin
            w++;
            @(negedge clk);
        end
        for (int k = 0; k < 16; k++) begin
            check_flag("cen12", cen12, (k % 2) == 0);
            check_flag("cen6", cen6, (k % 4) == 0);
            check_flag("cen3", cen3, (k % 8) == 0);
            @(negedge clk);
        end

        // Single miss then a hit in the same word, per reader
        for (int c = 0; c < NUM_CLI; c++) begin
            a = $urandom & ((c == 0) ? 16'hffff : (c == 1) ? 16'h7fff : 16'h3fff);
            do_read(client_e'(c), a, w);
            starts = req_starts;
            do_read(client_e'(c), a ^ 1, w);
            if (w != 0 || sdram_req || req_starts != starts) begin
                err_other++;
                $display("%0t: client %0d did not hit in its cached word", $time, c);
            end
        end

        fork
            random_reads(CLI_MAIN, MAIN_AW);
            random_reads(CLI_SND, SND_AW);
            random_reads(CLI_CHAR, CHAR_AW);
        join

        // Cache one main word, then download with a sound miss pending
        keep_addr = $urandom & 16'hffff;
        do_read(CLI_MAIN, keep_addr, w);
        @(posedge clk);
        #2;
        main_cs     = 1'b0;
        downloading = 1'b1;
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    send_byte(22'h000100 + 22'(i * 5), 8'(i * 37 + 3));
                end
                for (int p = 0; p < PROM_COUNT; p++) begin
                    send_byte(PROM_START + 22'(p * 256 + p * 3), 8'(8'h90 + p));
                end
                @(posedge clk);
                #2;
                downloading = 1'b0;
                for (int k = 1; k <= RST_HOLD; k++) begin
                    @(posedge clk);
                    @(negedge clk);
                    check_flag("core_rst", core_rst, k < RST_HOLD);
                end
            end
            do_read(CLI_SND, $urandom & 16'h7fff, w);
        join

        starts = req_starts;
        do_read(CLI_MAIN, keep_addr, w);
        if (req_starts == starts) begin
            err_other++;
            $display("%0t: main reader served a cached word after the download", $time);
        end

        @(posedge clk);
        #2;
        main_cs = 1'b0;
        snd_cs  = 1'b0;
        char_cs = 1'b0;
        repeat (4) @(posedge clk);
        $display("Done: %0d checks, %0d value errors, %0d other errors",
                 n_checks, err_val, err_other);
        if (err_val == 0 && err_other == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: game_rom_sys.f
game_pkg.sv
clk_en_gen.sv
rom_reader.sv
sdram_arbiter.sv
rom_loader.sv
game_rom_sys.sv
sdram_model.sv
game_rom_sys_chk.sv
tb_game_rom_sys.sv

// File: Makefile
SRCS := $(shell cat game_rom_sys.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_game_rom_sys: $(SRCS) game_rom_sys.f
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_game_rom_sys -f game_rom_sys.f

run: obj_dir/Vtb_game_rom_sys
	out=$$(./obj_dir/Vtb_game_rom_sys); \
	echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf obj_dir
